/* verilog.f */
rvseed_pkg.sv
inst_mem.sv
pc_unit.sv
ctrl.sv
imm_gen.sv
reg_file.sv
alu.sv
data_mem.sv
rvseed_top.sv
tb_checker.sv
tb_rvseed.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass or fail from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_rvseed -o tb_rvseed
./obj_dir/tb_rvseed | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation reported failure"
    exit 1
fi

/* tb_rvseed.sv */
// testbench top: clock, reset, program generation, program load, test sequencing, timeout
`timescale 1ns/100ps

module tb_rvseed import rvseed_pkg::*; ();

    localparam int PROG_MAX = 64;
    localparam int LIMIT    = 5 * (2 * PROG_MAX + 10);   // five tests, load + run + overhead

    logic               clk;
    logic               rst_n;
    logic               run;
    logic               load_en;
    logic [IMEM_AW-1:0] load_addr;
    word_t              load_data;
    addr_t              pc;
    logic               halt;
    logic               unknown_code;
    logic               retire_valid;
    addr_t              retire_pc;
    logic               retire_wen;
    reg_addr_t          retire_rd;
    word_t              retire_wdata;
    word_t              prog [PROG_MAX];
    int                 n;
    int                 cycles;
    int                 err_before;
    integer             seed;

    rvseed_top rvseed_top_i (.*);
    tb_checker checker_i (.*);

    function automatic int rnd(input int m);
        return ($random(seed) & 32'h7fff_ffff) % m;
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input int rs1, input logic [2:0] f3,
                                    input int rd, input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input int rs2, input int rs1,
                                    input logic [2:0] f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                    input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    task automatic push(input word_t w);
        prog[n] = w;
        n++;
    endtask

    // loads x1..x5 with random words
    task automatic random_regs();
        for (int r = 1; r <= 5; r++) begin
            push({20'($random(seed)), 5'(r), OP_LUI});
            push(enc_i(12'($random(seed)), r, 3'b000, r, OP_IMM));
        end
    endtask

    task automatic build(input int t);
        logic [2:0] f3;
        logic [2:0] bf3 [6];
        int         sz;
        int         ra;
        int         rb;
        n   = 0;
        bf3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        case (t)
            0: begin
                random_regs();
                for (int k = 0; k < 40; k++) begin
                    f3 = 3'(rnd(8));
                    case (rnd(4))
                        0: push(enc_r((f3 == 0 || f3 == 5) && rnd(2) ? 7'h20 : 7'h00,
                                      rnd(16), rnd(16), f3, rnd(16)));
                        1: push(enc_i(f3 == 1 || (f3 == 5 && rnd(2) == 0) ? 12'(rnd(32)) :
                                      f3 == 5 ? 12'h400 | 12'(rnd(32)) : 12'($random(seed)),
                                      rnd(16), f3, rnd(16), OP_IMM));
                        2: push({20'($random(seed)), 5'(rnd(16)), OP_LUI});
                        default: push({20'($random(seed)), 5'(rnd(16)), OP_AUIPC});
                    endcase
                end
                push(INST_EBREAK);
            end
            1: begin
                random_regs();
                push(enc_i(12'd512, 0, 3'b000, 1, OP_IMM));   // base for the data window
                for (int k = 0; k < 16; k++) begin
                    push(enc_s(12'(4 * k), 2 + k % 4, 1, 3'b010));
                end
                for (int k = 0; k < 12; k++) begin
                    sz = rnd(3);
                    push(enc_s(12'(rnd(64) & ~((1 << sz) - 1)), 2 + rnd(4), 1, 3'(sz)));
                    sz = rnd(5);
                    f3 = sz == 3 ? 3'b100 : sz == 4 ? 3'b101 : 3'(sz);
                    push(enc_i(12'(rnd(64) & ~((1 << f3[1:0]) - 1)), 1, f3, 6 + rnd(5),
                               OP_LOAD));
                end
                push(INST_EBREAK);
            end
            2: begin
                for (int r = 1; r <= 3; r++) begin
                    push(enc_i(12'(rnd(3)), 0, 3'b000, r, OP_IMM));   // small, often equal
                end
                push(enc_i(12'hffe, 0, 3'b000, 4, OP_IMM));
                // same register, then small against negative in both orders
                for (int k = 0; k < 18; k++) begin
                    ra = k < 6 ? 1 + rnd(4) : k < 12 ? 1 + rnd(3) : 4;
                    rb = k < 6 ? ra : k < 12 ? 4 : 1 + rnd(3);
                    push(enc_b(13'd8, rb, ra, bf3[k % 6]));
                    push(enc_i(12'd1, 5, 3'b000, 5, OP_IMM));
                end
                push({1'b0, 10'd4, 1'b0, 8'd0, 5'd6, OP_JAL});   // skip one
                push(enc_i(12'd1, 5, 3'b000, 5, OP_IMM));
                push({20'd0, 5'd7, OP_AUIPC});
                push(enc_i(12'd13, 7, 3'b000, 8, OP_JALR));   // odd target, lsb dropped
                push(enc_i(12'd1, 5, 3'b000, 5, OP_IMM));
                push(INST_EBREAK);
            end
            3: begin
                push(enc_i(12'd5, 0, 3'b000, 1, OP_IMM));
                push(INST_EBREAK);
                push(enc_i(12'd7, 0, 3'b000, 1, OP_IMM));
            end
            default: begin
                push(enc_i(12'd9, 0, 3'b000, 1, OP_IMM));
                push(32'hffff_ffff);
                push(enc_i(12'd3, 0, 3'b000, 2, OP_IMM));
            end
        endcase
    endtask

    task automatic run_test(input int t, input string name);
        build(t);
        err_before = checker_i.errors;
        @(posedge clk);
        rst_n <= 1'b0;
        run   <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= IMEM_AW'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        run     <= 1'b1;
        @(posedge clk);
        while (!halt) @(posedge clk);
        repeat (4) @(posedge clk);   // halted core must stay frozen
        run <= 1'b0;
        $display("test %0d %s done, %0d new errors", t, name, checker_i.errors - err_before);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles: the core never halted", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        seed      = 32'he4da;
        cycles    = 0;
        rst_n     = 1'b0;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        run_test(0, "register ops");
        run_test(1, "loads and stores");
        run_test(2, "control flow");
        run_test(3, "ebreak");
        run_test(4, "illegal");
        $display("checks %0d, errors %0d", checker_i.checks, checker_i.errors);
        if (checker_i.errors == 0 && checker_i.checks > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* tb_checker.sv */
// checker: instruction image, reference isa model and retire comparison
`timescale 1ns/100ps

module tb_checker import rvseed_pkg::*; (
    input logic               clk,
    input logic               rst_n,
    input logic               load_en,
    input logic [IMEM_AW-1:0] load_addr,
    input word_t              load_data,
    input addr_t              pc,
    input logic               halt,
    input logic               unknown_code,
    input logic               retire_valid,
    input addr_t              retire_pc,
    input logic               retire_wen,
    input reg_addr_t          retire_rd,
    input word_t              retire_wdata
);

    word_t      m_imem [IMEM_DEPTH];
    word_t      m_regs [32];
    logic [7:0] m_dmem [DMEM_DEPTH];   // zero at start, never cleared by reset
    addr_t      m_pc;
    logic       m_halted;
    logic       m_illegal;
    word_t      cur_ins;
    logic       exp_wen;
    word_t      exp_wd;
    int         errors = 0;
    int         checks = 0;

    initial begin
        for (int i = 0; i < DMEM_DEPTH; i++) m_dmem[i] = 8'h00;
    end

    function automatic word_t arith(input logic [2:0] f3, input logic alt, input word_t x,
                                    input word_t y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return {31'd0, $signed(x) < $signed(y)};
            3'b011:  return {31'd0, x < y};
            3'b100:  return x ^ y;
            3'b101:  return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    // one instruction of the reference model
    function automatic void model_step(input word_t ins, output logic wen, output word_t wd);
        logic [2:0]         f3;
        logic [6:0]         f7;
        word_t              a;
        word_t              b;
        word_t              ii;
        word_t              is;
        word_t              npc;
        word_t              ld;
        logic               bad;
        logic [DMEM_AW-1:0] ad;
        f3  = ins[14:12];
        f7  = ins[31:25];
        a   = m_regs[ins[19:15]];
        b   = m_regs[ins[24:20]];
        ii  = {{20{ins[31]}}, ins[31:20]};
        is  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        npc = m_pc + 32'd4;
        wen = 1'b0;
        wd  = '0;
        bad = 1'b0;
        case (ins[6:0])
            OP_LUI: begin
                wen = 1'b1;
                wd  = {ins[31:12], 12'h000};
            end
            OP_AUIPC: begin
                wen = 1'b1;
                wd  = m_pc + {ins[31:12], 12'h000};
            end
            OP_JAL: begin
                wen = 1'b1;
                wd  = m_pc + 32'd4;
                npc = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OP_JALR: begin
                bad = (f3 != 3'b000);
                wen = 1'b1;
                wd  = m_pc + 32'd4;
                npc = (a + ii) & ~32'd1;
            end
            OP_BRANCH: begin
                case (f3)
                    3'b000:  bad = 1'b0;
                    3'b001:  bad = 1'b0;
                    3'b100:  bad = 1'b0;
                    3'b101:  bad = 1'b0;
                    3'b110:  bad = 1'b0;
                    3'b111:  bad = 1'b0;
                    default: bad = 1'b1;
                endcase
                if (!bad && ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b) ||
                    (f3 == 3'b100 && $signed(a) < $signed(b)) ||
                    (f3 == 3'b101 && $signed(a) >= $signed(b)) ||
                    (f3 == 3'b110 && a < b) || (f3 == 3'b111 && a >= b))) begin
                    npc = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OP_LOAD: begin
                ad  = DMEM_AW'(a + ii);
                ld  = {m_dmem[DMEM_AW'(ad + 3)], m_dmem[DMEM_AW'(ad + 2)],
                       m_dmem[DMEM_AW'(ad + 1)], m_dmem[ad]};   // wraps like the array
                wen = 1'b1;
                case (f3)
                    3'b000:  wd = {{24{ld[7]}}, ld[7:0]};
                    3'b001:  wd = {{16{ld[15]}}, ld[15:0]};
                    3'b010:  wd = ld;
                    3'b100:  wd = {24'd0, ld[7:0]};
                    3'b101:  wd = {16'd0, ld[15:0]};
                    default: bad = 1'b1;
                endcase
            end
            OP_STORE: begin
                ad  = DMEM_AW'(a + is);
                bad = (f3 > 3'b010);
                if (!bad) m_dmem[ad] = b[7:0];
                if (f3 == 3'b001 || f3 == 3'b010) m_dmem[DMEM_AW'(ad + 1)] = b[15:8];
                if (f3 == 3'b010) begin
                    m_dmem[DMEM_AW'(ad + 2)] = b[23:16];
                    m_dmem[DMEM_AW'(ad + 3)] = b[31:24];
                end
            end
            OP_IMM: begin
                wen = 1'b1;
                bad = (f3 == 3'b001 && f7 != 7'h00) ||
                      (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
                wd  = arith(f3, f3 == 3'b101 && f7[5], a, ii);
            end
            OP_REG: begin
                wen = 1'b1;
                bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
                wd  = arith(f3, f7[5], a, b);
            end
            OP_SYSTEM: begin
                bad      = (ins != INST_EBREAK);
                m_halted = 1'b1;
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            wen       = 1'b0;
            m_halted  = 1'b1;
            m_illegal = 1'b1;
        end
        wen = wen && (ins[11:7] != 5'd0);
        if (wen) m_regs[ins[11:7]] = wd;
        m_pc = npc;
    endfunction

    task automatic expect_eq(input word_t got, input word_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) m_regs[i] = '0;
            m_pc      = RESET_PC;
            m_halted  = 1'b0;
            m_illegal = 1'b0;
        end else begin
            if (load_en) m_imem[load_addr] = load_data;
            if (m_halted) begin
                expect_eq(32'(halt), 32'd1, "halt");
                expect_eq(32'(unknown_code), 32'(m_illegal), "unknown_code");
                expect_eq(pc, m_pc, "halted pc");   // parked just past the halting instruction
                if (retire_valid) begin
                    errors++;
                    $display("a retire appeared at %0t after the core halted", $time);
                end
            end else if (retire_valid) begin
                expect_eq(32'(halt | unknown_code), 32'd0, "halt flags");
                expect_eq(retire_pc, m_pc, "retire_pc");
                cur_ins = m_pc[XLEN-1:IMEM_AW+2] == '0 ? m_imem[m_pc[IMEM_AW+1:2]] : '0;
                model_step(cur_ins, exp_wen, exp_wd);
                expect_eq(32'(retire_wen), 32'(exp_wen), "retire_wen");
                if (exp_wen) begin
                    expect_eq(32'(retire_rd), 32'(cur_ins[11:7]), "retire_rd");
                    expect_eq(retire_wdata, exp_wd, "retire_wdata");
                end
            end
        end
    end

endmodule

/* rvseed_top.sv */
// single-cycle rv32i core top: block wiring, write-back select, halt flags, retire port
`timescale 1ns/100ps

module rvseed_top import rvseed_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               load_en,
    input  logic [IMEM_AW-1:0] load_addr,
    input  word_t              load_data,
    output addr_t              pc,
    output logic               halt,
    output logic               unknown_code,
    output logic               retire_valid,
    output addr_t              retire_pc,
    output logic               retire_wen,
    output reg_addr_t          retire_rd,
    output word_t              retire_wdata
);

    word_t     inst;
    addr_t     pc_plus4;
    logic      advance;      // one instruction executes this cycle
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      reg_wen;
    imm_fmt_t  imm_fmt;
    alu_op_t   alu_op;
    logic      src1_pc;
    logic      src2_imm;
    logic      mem_read;
    logic      mem_write;
    mem_size_t mem_size;
    logic      mem_unsigned;
    logic      branch;
    logic      jump;
    logic      jalr;
    logic      ebreak;
    logic      illegal;
    word_t     imm;
    word_t     rdata1;
    word_t     rdata2;
    word_t     alu_res;
    logic      taken;
    word_t     load_rdata;
    word_t     wb_data;

    assign advance = run && !halt;

    inst_mem u_inst_mem_0 (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (pc),
        .inst      (inst)
    );

    pc_unit u_pc_unit_0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .branch   (branch),
        .jump     (jump),
        .jalr     (jalr),
        .taken    (taken),
        .imm      (imm),
        .alu_res  (alu_res),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    ctrl u_ctrl_0 (
        .inst         (inst),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .reg_wen      (reg_wen),
        .imm_fmt      (imm_fmt),
        .alu_op       (alu_op),
        .src1_pc      (src1_pc),
        .src2_imm     (src2_imm),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .branch       (branch),
        .jump         (jump),
        .jalr         (jalr),
        .ebreak       (ebreak),
        .illegal      (illegal)
    );

    imm_gen u_imm_gen_0 (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    reg_file u_reg_file_0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (advance && reg_wen),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu u_alu_0 (
        .alu_op    (alu_op),
        .src1_pc   (src1_pc),
        .src2_imm  (src2_imm),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .imm       (imm),
        .pc        (pc),
        .branch_f3 (inst[14:12]),
        .alu_res   (alu_res),
        .taken     (taken)
    );

    data_mem u_data_mem_0 (
        .clk          (clk),
        .mem_read     (mem_read),
        .mem_write    (advance && mem_write),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .addr         (alu_res),
        .wdata        (rdata2),
        .rdata        (load_rdata)
    );

    // write-back: load data, link address or alu result
    always_comb begin
        if (mem_read) begin
            wb_data = load_rdata;
        end else if (jump || jalr) begin
            wb_data = pc_plus4;
        end else begin
            wb_data = alu_res;
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt         <= 1'b0;
            unknown_code <= 1'b0;
        end else if (advance) begin
            if (ebreak || illegal) begin
                halt <= 1'b1;
            end
            if (illegal) begin
                unknown_code <= 1'b1;
            end
        end
    end

    assign retire_valid = advance;
    assign retire_pc    = pc;
    assign retire_wen   = advance && reg_wen;   // reg_wen already excludes x0
    assign retire_rd    = rd;
    assign retire_wdata = wb_data;

endmodule

/* data_mem.sv */
// little-endian byte data memory with sized stores and extended loads
`timescale 1ns/100ps

module data_mem import rvseed_pkg::*; (
    input  logic      clk,
    input  logic      mem_read,
    input  logic      mem_write,
    input  mem_size_t mem_size,
    input  logic      mem_unsigned,
    input  addr_t     addr,
    input  word_t     wdata,
    output word_t     rdata
);

    logic [7:0]         mem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] a0;
    logic [DMEM_AW-1:0] a1;
    logic [DMEM_AW-1:0] a2;
    logic [DMEM_AW-1:0] a3;
    word_t              raw;
    logic               sgn;

    // byte lanes wrap inside the array
    assign a0 = addr[DMEM_AW-1:0];
    assign a1 = a0 + DMEM_AW'(1);
    assign a2 = a0 + DMEM_AW'(2);
    assign a3 = a0 + DMEM_AW'(3);

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[a0] <= wdata[7:0];
            if (mem_size != MEM_B) begin
                mem[a1] <= wdata[15:8];
            end
            if (mem_size == MEM_W) begin
                mem[a2] <= wdata[23:16];
                mem[a3] <= wdata[31:24];
            end
        end
    end

    assign raw = {mem[a3], mem[a2], mem[a1], mem[a0]};
    assign sgn = !mem_unsigned;

    always_comb begin
        case (mem_size)
            MEM_B:   rdata = {{24{sgn & raw[7]}}, raw[7:0]};
            MEM_H:   rdata = {{16{sgn & raw[15]}}, raw[15:0]};
            default: rdata = raw;
        endcase
        if (!mem_read) begin
            rdata = '0;
        end
    end

endmodule

/* alu.sv */
// operand select, integer operations and branch condition
`timescale 1ns/100ps

module alu import rvseed_pkg::*; (
    input  alu_op_t    alu_op,
    input  logic       src1_pc,
    input  logic       src2_imm,
    input  word_t      rdata1,
    input  word_t      rdata2,
    input  word_t      imm,
    input  addr_t      pc,
    input  logic [2:0] branch_f3,
    output word_t      alu_res,
    output logic       taken
);

    word_t op1;
    word_t op2;
    logic  zero;

    assign op1 = src1_pc  ? pc  : rdata1;
    assign op2 = src2_imm ? imm : rdata2;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_res = op1 + op2;
            ALU_SUB:  alu_res = op1 - op2;
            ALU_SLL:  alu_res = op1 << op2[4:0];
            ALU_SLT:  alu_res = {31'd0, $signed(op1) < $signed(op2)};
            ALU_SLTU: alu_res = {31'd0, op1 < op2};
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_SRL:  alu_res = op1 >> op2[4:0];
            ALU_SRA:  alu_res = $signed(op1) >>> op2[4:0];
            ALU_OR:   alu_res = op1 | op2;
            ALU_AND:  alu_res = op1 & op2;
            ALU_PASS: alu_res = op2;
            default:  alu_res = '0;
        endcase
    end

    assign zero = (alu_res == '0);

    // sub for beq/bne, slt(u) for the ordered compares
    always_comb begin
        case (branch_f3)
            3'b000:        taken = zero;
            3'b001:        taken = !zero;
            3'b100, 3'b110: taken = alu_res[0];
            3'b101, 3'b111: taken = !alu_res[0];
            default:       taken = 1'b0;
        endcase
    end

endmodule

/* reg_file.sv */
// 32 x 32 register file, two combinational reads, one write, x0 tied to zero
`timescale 1ns/100ps

module reg_file import rvseed_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wen,
    input  reg_addr_t waddr,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [2**REG_ADDR_WIDTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin   // x0 never written
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* imm_gen.sv */
// immediate extraction and sign extension for i, s, b, u and j formats
`timescale 1ns/100ps

module imm_gen import rvseed_pkg::*; (
    input  word_t    inst,
    input  imm_fmt_t imm_fmt,
    output word_t    imm
);

    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            IMM_S: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {inst[31:12], 12'h000};
            end
            IMM_J: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

/* ctrl.sv */
// instruction decoder: register fields, alu, memory and flow controls, ebreak and illegal flags
`timescale 1ns/100ps

module ctrl import rvseed_pkg::*; (
    input  word_t     inst,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output logic      reg_wen,
    output imm_fmt_t  imm_fmt,
    output alu_op_t   alu_op,
    output logic      src1_pc,
    output logic      src2_imm,
    output logic      mem_read,
    output logic      mem_write,
    output mem_size_t mem_size,
    output logic      mem_unsigned,
    output logic      branch,
    output logic      jump,
    output logic      jalr,
    output logic      ebreak,
    output logic      illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       writes_rd;   // encoding has a destination

    // integer op from funct3, alt picks sub / sra
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign reg_wen      = writes_rd && (rd != '0) && !illegal;
    assign mem_size     = funct3[1:0];
    assign mem_unsigned = funct3[2];

    always_comb begin
        writes_rd = 1'b0;
        imm_fmt   = IMM_I;
        alu_op    = ALU_ADD;
        src1_pc   = 1'b0;
        src2_imm  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jalr      = 1'b0;
        ebreak    = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            OP_LUI: begin
                writes_rd = 1'b1;
                imm_fmt   = IMM_U;
                alu_op    = ALU_PASS;
                src2_imm  = 1'b1;
            end
            OP_AUIPC: begin
                writes_rd = 1'b1;
                imm_fmt   = IMM_U;
                src1_pc   = 1'b1;
                src2_imm  = 1'b1;
            end
            OP_JAL: begin
                writes_rd = 1'b1;
                imm_fmt   = IMM_J;
                jump      = 1'b1;
            end
            OP_JALR: begin
                writes_rd = 1'b1;
                src2_imm  = 1'b1;
                jalr      = 1'b1;
                illegal   = (funct3 != 3'b000);
            end
            OP_BRANCH: begin
                imm_fmt = IMM_B;
                branch  = 1'b1;
                case (funct3[2:1])     // compare kind chosen here, sense in alu
                    2'b00:   alu_op = ALU_SUB;
                    2'b10:   alu_op = ALU_SLT;
                    2'b11:   alu_op = ALU_SLTU;
                    default: illegal = 1'b1;
                endcase
            end
            OP_LOAD: begin
                writes_rd = 1'b1;
                src2_imm  = 1'b1;
                mem_read  = 1'b1;
                illegal   = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OP_STORE: begin
                imm_fmt   = IMM_S;
                src2_imm  = 1'b1;
                mem_write = !(funct3[2] || funct3[1:0] == 2'b11);
                illegal   = funct3[2] || (funct3[1:0] == 2'b11);
            end
            OP_IMM: begin
                writes_rd = 1'b1;
                src2_imm  = 1'b1;
                alu_op    = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
                if (funct3 == 3'b001) begin
                    illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            OP_REG: begin
                writes_rd = 1'b1;
                alu_op    = arith_op(funct3, funct7[5]);
                illegal   = !((funct7 == 7'b0000000) ||
                              (funct7 == 7'b0100000 &&
                               (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OP_SYSTEM: begin
                ebreak  = (inst == INST_EBREAK);
                illegal = (inst != INST_EBREAK);   // ecall and csr ops not kept
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* pc_unit.sv */
// program counter register and next pc selection
`timescale 1ns/100ps

module pc_unit import rvseed_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  advance,     // run and not halted
    input  logic  branch,
    input  logic  jump,
    input  logic  jalr,
    input  logic  taken,
    input  word_t imm,
    input  word_t alu_res,
    output addr_t pc,
    output addr_t pc_plus4
);

    addr_t next_pc;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (jalr) begin
            next_pc = {alu_res[XLEN-1:1], 1'b0};   // rs1 + imm, lsb cleared
        end else if (jump || (branch && taken)) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (advance) begin
            pc <= next_pc;
        end
    end

endmodule

/* inst_mem.sv */
// instruction memory: word array loaded by strobe, combinational fetch by pc
`timescale 1ns/100ps

module inst_mem import rvseed_pkg::*; (
    input  logic               clk,
    input  logic               load_en,
    input  logic [IMEM_AW-1:0] load_addr,
    input  word_t              load_data,
    input  addr_t              pc,
    output word_t              inst
);

    word_t mem [IMEM_DEPTH];
    logic  in_range;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // word index sits above the byte offset
    assign in_range = (pc[XLEN-1:IMEM_AW+2] == '0);

    // outside the array reads as zero, which ctrl rejects as illegal
    assign inst = in_range ? mem[pc[IMEM_AW+1:2]] : '0;

endmodule

/* rvseed_pkg.sv */
// shared widths, typedefs, opcodes, alu operations, immediate formats and access sizes
package rvseed_pkg;

    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;

    typedef logic [XLEN-1:0]           word_t;
    typedef logic [XLEN-1:0]           addr_t;      // byte address
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // memory sizes
    localparam int IMEM_DEPTH = 256;               // words
    localparam int IMEM_AW    = 8;
    localparam int DMEM_DEPTH = 1024;              // bytes
    localparam int DMEM_AW    = 10;

    localparam addr_t RESET_PC = 32'h0000_0000;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam word_t INST_EBREAK = 32'h0010_0073; // only system encoding kept

    typedef logic [3:0] alu_op_t;
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;
    localparam alu_op_t ALU_PASS = 4'd10;          // second operand through, for lui

    typedef logic [2:0] imm_fmt_t;
    localparam imm_fmt_t IMM_I = 3'd0;
    localparam imm_fmt_t IMM_S = 3'd1;
    localparam imm_fmt_t IMM_B = 3'd2;
    localparam imm_fmt_t IMM_U = 3'd3;
    localparam imm_fmt_t IMM_J = 3'd4;

    // encoded as funct3[1:0] of loads and stores
    typedef logic [1:0] mem_size_t;
    localparam mem_size_t MEM_B = 2'd0;
    localparam mem_size_t MEM_H = 2'd1;
    localparam mem_size_t MEM_W = 2'd2;

endpackage
